// File: usb_tx.f
+incdir+.
usb_tx_pkg.sv
tx_bit_if.sv
usb_crc_gen.sv
usb_pkt_serializer.sv
usb_bit_stuffer.sv
usb_line_driver.sv
usb_tx.sv
usb_tx_checker.sv
usb_tx_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the usb transmit testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f usb_tx.f --top-module usb_tx_tb -o usb_tx_sim
./obj_dir/usb_tx_sim | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
  exit 0
else
  exit 1
fi

// File: usb_tx_tb.sv
// usb transmit testbench
// seeded random packets checked pair by pair against a model of the
// serializer, bit stuffing and nrzi line coding
`timescale 1ns/1ns
`include "usb_tx_cfg.svh"

module usb_tx_tb;
  import usb_tx_pkg::*;

  localparam int START_LIMIT = 20;
  localparam int PKT_LIMIT   = 400;
  localparam int NUM_RANDOM  = 8;

  logic                      clk;
  logic                      rst_L;
  logic                      pkt_avail;
  pid_e                      pid;
  logic [`USB_ADDR_BITS-1:0] addr;
  logic [`USB_ENDP_BITS-1:0] endp;
  logic [`USB_DATA_BITS-1:0] data;
  logic                      dp;
  logic                      dm;
  logic                      line_en;
  logic                      pkt_sent;

  integer     seed;
  int         error_count;
  int         test_count;
  int         failed_tests;
  int         sent_count;
  bit         raw_q[$];
  logic [1:0] exp_q[$];
  logic [1:0] act_q[$];

  usb_tx UUT (
    .clk      (clk),
    .rst_L    (rst_L),
    .pkt_avail(pkt_avail),
    .pid      (pid),
    .addr     (addr),
    .endp     (endp),
    .data     (data),
    .dp       (dp),
    .dm       (dm),
    .line_en  (line_en),
    .pkt_sent (pkt_sent)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // one cycle, ending just after the rising edge where outputs have settled
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s expected %0h actual %0h", name, expected, actual);
      error_count++;
    end
  endtask

  // usb crc over nbits of msg taken lsb first and preset to all ones
  function automatic logic [15:0] crc_of(input logic [63:0] msg, input int nbits,
                                         input int width, input logic [15:0] poly);
    logic [15:0] mask;
    logic [15:0] r;
    logic        fb;
    mask = 16'((32'd1 << width) - 32'd1);
    r    = mask;
    for (int i = 0; i < nbits; i++) begin
      fb = r[width-1] ^ msg[i];
      r  = ((r << 1) & mask) ^ (fb ? poly : 16'h0);
    end
    return r;
  endfunction

  task automatic build_expected(input pid_e p, input logic [`USB_ADDR_BITS-1:0] a,
                                input logic [`USB_ENDP_BITS-1:0] e,
                                input logic [`USB_DATA_BITS-1:0] d);
    logic [`USB_PID_BITS-1:0] pv;
    logic [15:0]              crc;
    logic                     level;
    int                       ones;
    pv = p;
    raw_q.delete();
    exp_q.delete();
    for (int i = 0; i < `USB_SYNC_BITS; i++) begin
      raw_q.push_back(i == `USB_SYNC_BITS - 1);
    end
    for (int i = 0; i < `USB_PID_BITS; i++) begin
      raw_q.push_back(pv[i]);
    end
    if (p == OUT || p == IN) begin
      for (int i = 0; i < `USB_ADDR_BITS; i++) begin
        raw_q.push_back(a[i]);
      end
      for (int i = 0; i < `USB_ENDP_BITS; i++) begin
        raw_q.push_back(e[i]);
      end
      crc = crc_of(64'({e, a}), `USB_ADDR_BITS + `USB_ENDP_BITS, `USB_CRC5_BITS,
                   16'(`USB_CRC5_POLY));
      for (int i = `USB_CRC5_BITS - 1; i >= 0; i--) begin
        raw_q.push_back(~crc[i]);
      end
    end else if (p == DATA0) begin
      for (int i = 0; i < `USB_DATA_BITS; i++) begin
        raw_q.push_back(d[i]);
      end
      crc = crc_of(d, `USB_DATA_BITS, `USB_CRC16_BITS, 16'(`USB_CRC16_POLY));
      for (int i = `USB_CRC16_BITS - 1; i >= 0; i--) begin
        raw_q.push_back(~crc[i]);
      end
    end
    // nrzi starts at J and ones are counted from the first pid bit
    level = 1'b1;
    ones  = 0;
    for (int i = 0; i < raw_q.size(); i++) begin
      if (!raw_q[i]) begin
        level = ~level;
      end
      exp_q.push_back({level, ~level});
      if (i >= `USB_SYNC_BITS) begin
        ones = raw_q[i] ? ones + 1 : 0;
        if (ones == `USB_STUFF_RUN) begin
          // stuffed zero toggles the line
          level = ~level;
          exp_q.push_back({level, ~level});
          ones = 0;
        end
      end
    end
    for (int i = 0; i < `USB_EOP_SE0_CYCLES; i++) begin
      exp_q.push_back(2'b00);
    end
    exp_q.push_back(2'b10);
  endtask

  // sends one packet and compares the line
  // with inject set, another pid is pulsed while the line is still busy
  task automatic run_test(input string name, input pid_e p,
                          input logic [`USB_ADDR_BITS-1:0] a,
                          input logic [`USB_ENDP_BITS-1:0] e,
                          input logic [`USB_DATA_BITS-1:0] d,
                          input bit inject, input pid_e other);
    int errs_before;
    int errs_pairs;
    int cyc;
    errs_before = error_count;
    build_expected(p, a, e, d);
    act_q.delete();
    sent_count = 0;
    pid        = p;
    addr       = a;
    endp       = e;
    data       = d;
    pkt_avail  = 1'b1;
    tick();
    pkt_avail = 1'b0;
    cyc = 0;
    while (!line_en && cyc < START_LIMIT) begin
      tick();
      cyc++;
    end
    if (!line_en) begin
      $display("%s: timeout, line_en never rose after pkt_avail", name);
      error_count++;
    end
    cyc = 0;
    while (line_en && cyc < PKT_LIMIT) begin
      act_q.push_back({dp, dm});
      if (pkt_sent) begin
        sent_count++;
      end
      // mid packet and all through the eop, when only the line is busy
      if (inject && (cyc == 10 || {dp, dm} == 2'b00 || pkt_sent)) begin
        pid       = other;
        pkt_avail = 1'b1;
      end else begin
        pkt_avail = 1'b0;
      end
      tick();
      cyc++;
    end
    pkt_avail = 1'b0;
    if (line_en) begin
      $display("%s: timeout, line_en stuck high", name);
      error_count++;
    end
    errs_pairs = error_count;
    for (int i = 0; i < exp_q.size() && i < act_q.size(); i++) begin
      check_value($sformatf("%s pair %0d", name, i), 64'(exp_q[i]), 64'(act_q[i]));
      if (error_count != errs_pairs) begin
        break;
      end
    end
    check_value({name, " length"}, 64'(exp_q.size()), 64'(act_q.size()));
    check_value({name, " pkt_sent count"}, 64'(1), 64'(sent_count));
    // an accepted second pulse would restart the line here
    repeat (10) tick();
    check_value({name, " idle after packet"}, 64'(0), 64'(line_en));
    test_count++;
    if (error_count == errs_before) begin
      $display("%s: ok, %0d line cycles", name, act_q.size());
    end else begin
      failed_tests++;
      $display("%s: mismatch", name);
    end
  endtask

  initial begin
    pid_e                      p;
    logic [`USB_ADDR_BITS-1:0] a;
    logic [`USB_ENDP_BITS-1:0] e;
    logic [`USB_DATA_BITS-1:0] d;
    int                        errs_before;
    seed         = 97670;
    error_count  = 0;
    test_count   = 0;
    failed_tests = 0;
    rst_L        = 1'b0;
    pkt_avail    = 1'b0;
    pid          = ACK;
    addr         = '0;
    endp         = '0;
    data         = '0;
    repeat (4) @(posedge clk);
    #1;
    rst_L = 1'b1;
    tick();

    errs_before = error_count;
    check_value("reset dp", 64'(1), 64'(dp));
    check_value("reset dm", 64'(0), 64'(dm));
    check_value("reset line_en", 64'(0), 64'(line_en));
    check_value("reset pkt_sent", 64'(0), 64'(pkt_sent));
    test_count++;
    if (error_count == errs_before) begin
      $display("reset_state: ok");
    end else begin
      failed_tests++;
      $display("reset_state: mismatch");
    end

    for (int n = 0; n < NUM_RANDOM; n++) begin
      p = (($random(seed) & 1) != 0) ? IN : OUT;
      a = 7'($random(seed));
      e = 4'($random(seed));
      run_test($sformatf("token_%0d", n), p, a, e, '0, 1'b0, ACK);
    end
    for (int n = 0; n < NUM_RANDOM; n++) begin
      d = {$random(seed), $random(seed)};
      run_test($sformatf("data0_%0d", n), DATA0, '0, '0, d, 1'b0, ACK);
    end
    run_test("ack", ACK, 7'($random(seed)), 4'($random(seed)), '0, 1'b0, ACK);
    run_test("nak", NAK, 7'($random(seed)), 4'($random(seed)), '0, 1'b0, ACK);
    run_test("data0_all_ones", DATA0, '0, '0, '1, 1'b0, ACK);
    run_test("out_addr_all_ones", OUT, '1, 4'($random(seed)), '0, 1'b0, ACK);
    run_test("in_all_ones", IN, '1, '1, '0, 1'b0, ACK);
    d = {$random(seed), $random(seed)};
    run_test("busy_pulse_ignored", DATA0, '0, '0, d, 1'b1, NAK);

    $display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule : usb_tx_tb

// File: usb_tx_checker.sv
// usb transmit line checker
// concurrent assertions on the d+/d- levels and the pkt_sent strobe
`timescale 1ns/1ns

module usb_tx_checker (
  input logic clk,
  input logic rst_L,
  input logic dp,
  input logic dm,
  input logic line_en,
  input logic pkt_sent
);

  // se1 is never a legal line state
  a_no_se1: assert property (@(posedge clk) disable iff (!rst_L) !(dp && dm))
    else $error("dp and dm both high");

  // pkt_sent only while the line is driven
  a_sent_on_line: assert property (@(posedge clk) disable iff (!rst_L)
    pkt_sent |-> line_en)
    else $error("pkt_sent high with line_en low");

  a_sent_pulse: assert property (@(posedge clk) disable iff (!rst_L)
    pkt_sent |=> !pkt_sent)
    else $error("pkt_sent held for more than one cycle");

  // line released right after the closing j
  a_release: assert property (@(posedge clk) disable iff (!rst_L)
    pkt_sent |=> !line_en)
    else $error("line_en still high after pkt_sent");

endmodule : usb_tx_checker

bind usb_tx usb_tx_checker u_tx_checker (
  .clk     (clk),
  .rst_L   (rst_L),
  .dp      (dp),
  .dm      (dm),
  .line_en (line_en),
  .pkt_sent(pkt_sent)
);

// File: usb_tx.sv
// usb transmit path top
// serializer, bit stuffer and line driver in a row, packet fields
// taken as plain ports
`timescale 1ns/1ns
`include "usb_tx_cfg.svh"

module usb_tx (
  input  logic                      clk,
  input  logic                      rst_L,
  input  logic                      pkt_avail,
  input  usb_tx_pkg::pid_e          pid,
  input  logic [`USB_ADDR_BITS-1:0] addr,
  input  logic [`USB_ENDP_BITS-1:0] endp,
  input  logic [`USB_DATA_BITS-1:0] data,
  output logic                      dp,
  output logic                      dm,
  output logic                      line_en,
  output logic                      pkt_sent
);
  import usb_tx_pkg::*;

  tx_pkt_t pkt;
  logic    line_bit;
  logic    line_active;
  logic    line_last;
  logic    line_busy;

  tx_bit_if bits_if ();

  assign pkt = '{pid: pid, addr: addr, endp: endp, data: data};

  usb_pkt_serializer ser (
    .clk      (clk),
    .rst_L    (rst_L),
    .pkt_avail(pkt_avail),
    .pkt      (pkt),
    .line_busy(line_busy),
    .bits     (bits_if.ser)
  );

  usb_bit_stuffer stuffer (
    .clk        (clk),
    .rst_L      (rst_L),
    .bits       (bits_if.stuff),
    .line_bit   (line_bit),
    .line_active(line_active),
    .line_last  (line_last)
  );

  usb_line_driver driver (
    .clk        (clk),
    .rst_L      (rst_L),
    .line_bit   (line_bit),
    .line_active(line_active),
    .line_last  (line_last),
    .dp         (dp),
    .dm         (dm),
    .line_en    (line_en),
    .pkt_sent   (pkt_sent),
    .line_busy  (line_busy)
  );

endmodule : usb_tx

// File: usb_line_driver.sv
// usb line driver
// nrzi encodes the stuffed stream onto d+/d- and closes each packet
// with se0 and a final j cycle
`timescale 1ns/1ns
`include "usb_tx_cfg.svh"

module usb_line_driver (
  input  logic clk,
  input  logic rst_L,
  input  logic line_bit,
  input  logic line_active,
  input  logic line_last,
  output logic dp,
  output logic dm,
  output logic line_en,
  output logic pkt_sent,
  output logic line_busy
);

  localparam int SE0_W = $clog2(`USB_EOP_SE0_CYCLES + 1);

  typedef enum logic [1:0] {IDLE, PACKET, SE0, EOP_J} state_e;

  state_e           state;
  // line level, 1 is J
  logic             level;
  logic             nrzi_next;
  logic             last_q;
  logic [SE0_W-1:0] se0_cnt;

  // a one keeps the level, a zero flips it
  assign nrzi_next = line_bit ? level : ~level;

  always_ff @(posedge clk or negedge rst_L) begin
    if (!rst_L) begin
      state   <= IDLE;
      level   <= 1'b1;
      last_q  <= 1'b0;
      se0_cnt <= '0;
    end else begin
      // set while the final bit is on the line
      last_q <= line_active && line_last;
      case (state)
        IDLE: begin
          if (line_active) begin
            state <= PACKET;
            level <= nrzi_next;
          end
        end
        PACKET: begin
          if (last_q) begin
            state   <= SE0;
            se0_cnt <= '0;
            // next packet starts from J again
            level   <= 1'b1;
          end else if (line_active) begin
            level <= nrzi_next;
          end
        end
        SE0: begin
          if (se0_cnt == SE0_W'(`USB_EOP_SE0_CYCLES - 1)) begin
            state   <= EOP_J;
            se0_cnt <= '0;
          end else begin
            se0_cnt <= se0_cnt + 1'b1;
          end
        end
        EOP_J:   state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_comb begin
    case (state)
      PACKET: begin
        dp = level;
        dm = ~level;
      end
      SE0: begin
        dp = 1'b0;
        dm = 1'b0;
      end
      // idle and the closing cycle both sit at J
      default: begin
        dp = 1'b1;
        dm = 1'b0;
      end
    endcase
  end

  assign line_en   = (state != IDLE);
  assign pkt_sent  = (state == EOP_J);
  assign line_busy = (state != IDLE);

endmodule : usb_line_driver

// File: usb_bit_stuffer.sv
// bit stuffer
// passes the raw stream through and slips in a zero after a run of ones,
// stalling the serializer for that cycle
`timescale 1ns/1ns
`include "usb_tx_cfg.svh"

module usb_bit_stuffer (
  input  logic     clk,
  input  logic     rst_L,
  tx_bit_if.stuff  bits,
  output logic     line_bit,
  output logic     line_active,
  output logic     line_last
);

  localparam int RUN_W = $clog2(`USB_STUFF_RUN + 1);

  typedef enum logic [1:0] {IDLE, COUNTING, STALL} state_e;

  state_e           state;
  logic [RUN_W-1:0] ones_cnt;
  logic             last_pend;
  logic             counting;
  logic             hit;
  logic             stall;

  // counting begins with the first pid bit
  assign counting = (state == COUNTING) ||
                    ((state == IDLE) && bits.active && bits.stuff_start);

  // current bit completes the run
  assign hit = counting && bits.data_bit && (ones_cnt == RUN_W'(`USB_STUFF_RUN - 1));

  assign stall      = (state == STALL);
  assign bits.stall = stall;

  assign line_bit    = stall ? 1'b0 : bits.data_bit;
  assign line_active = bits.active || stall;
  // when the final bit triggers a stuff, last rides on the stuffed zero
  assign line_last   = stall ? last_pend : (bits.active && bits.last && !hit);

  always_ff @(posedge clk or negedge rst_L) begin
    if (!rst_L) begin
      state     <= IDLE;
      ones_cnt  <= '0;
      last_pend <= 1'b0;
    end else begin
      case (state)
        IDLE:     if (counting) state <= hit ? STALL : COUNTING;
        COUNTING: begin
          if (hit) begin
            state <= STALL;
          end else if (bits.active && bits.last) begin
            state <= IDLE;
          end
        end
        STALL:    state <= last_pend ? IDLE : COUNTING;
        default:  state <= IDLE;
      endcase
      ones_cnt  <= (counting && bits.data_bit && !hit) ? ones_cnt + 1'b1 : '0;
      last_pend <= hit && bits.last;
    end
  end

endmodule : usb_bit_stuffer

// File: usb_pkt_serializer.sv
// packet serializer
// turns a latched packet into sync, pid, fields and crc, one bit per
// cycle unless the stuffer stalls
`timescale 1ns/1ns
`include "usb_tx_cfg.svh"

module usb_pkt_serializer (
  input  logic                clk,
  input  logic                rst_L,
  input  logic                pkt_avail,
  input  usb_tx_pkg::tx_pkt_t pkt,
  input  logic                line_busy,
  tx_bit_if.ser               bits
);
  import usb_tx_pkg::*;

  localparam int CNT_W   = $clog2(`USB_DATA_BITS);
  localparam int PID_IW  = $clog2(`USB_PID_BITS);
  localparam int ADDR_IW = $clog2(`USB_ADDR_BITS);
  localparam int ENDP_IW = $clog2(`USB_ENDP_BITS);
  localparam int C5_IW   = $clog2(`USB_CRC5_BITS);
  localparam int C16_IW  = $clog2(`USB_CRC16_BITS);

  typedef enum logic [2:0] {
    IDLE, SYNC, PID, ADDR, ENDP, CRC5, DATA, CRC16
  } state_e;

  state_e                     state;
  logic [CNT_W-1:0]           bit_cnt;
  logic [CNT_W-1:0]           field_end;
  logic                       field_done;
  tx_pkt_t                    pkt_q;
  logic [`USB_PID_BITS-1:0]   pid_bits;
  logic                       pid_is_token;
  logic                       pid_is_data;
  logic                       accept;
  logic                       step;
  logic                       data_bit;
  logic                       last;
  logic [`USB_CRC5_BITS-1:0]  crc5_rem;
  logic [`USB_CRC16_BITS-1:0] crc16_rem;
  logic [C5_IW-1:0]           crc5_idx;
  logic [C16_IW-1:0]          crc16_idx;

  // only take a packet when both this stage and the line are quiet
  assign accept = (state == IDLE) && pkt_avail && !line_busy;
  assign step   = (state != IDLE) && !bits.stall;

  assign pid_bits     = pkt_q.pid;
  assign pid_is_token = (pkt_q.pid == OUT) || (pkt_q.pid == IN);
  assign pid_is_data  = (pkt_q.pid == DATA0);

  // remainders go out msb first
  assign crc5_idx  = C5_IW'(`USB_CRC5_BITS - 1) - bit_cnt[C5_IW-1:0];
  assign crc16_idx = C16_IW'(`USB_CRC16_BITS - 1) - bit_cnt[C16_IW-1:0];

  always_comb begin
    field_end = '0;
    data_bit  = 1'b0;
    case (state)
      SYNC: begin
        field_end = CNT_W'(`USB_SYNC_BITS - 1);
        data_bit  = (bit_cnt == field_end);
      end
      PID: begin
        field_end = CNT_W'(`USB_PID_BITS - 1);
        data_bit  = pid_bits[bit_cnt[PID_IW-1:0]];
      end
      ADDR: begin
        field_end = CNT_W'(`USB_ADDR_BITS - 1);
        data_bit  = pkt_q.addr[bit_cnt[ADDR_IW-1:0]];
      end
      ENDP: begin
        field_end = CNT_W'(`USB_ENDP_BITS - 1);
        data_bit  = pkt_q.endp[bit_cnt[ENDP_IW-1:0]];
      end
      CRC5: begin
        field_end = CNT_W'(`USB_CRC5_BITS - 1);
        data_bit  = ~crc5_rem[crc5_idx];
      end
      DATA: begin
        field_end = CNT_W'(`USB_DATA_BITS - 1);
        data_bit  = pkt_q.data[bit_cnt];
      end
      CRC16: begin
        field_end = CNT_W'(`USB_CRC16_BITS - 1);
        data_bit  = ~crc16_rem[crc16_idx];
      end
      default: begin
        field_end = '0;
        data_bit  = 1'b0;
      end
    endcase
  end

  assign field_done = (bit_cnt == field_end);

  // handshake packets stop after the pid
  always_comb begin
    case (state)
      PID:          last = field_done && !pid_is_token && !pid_is_data;
      CRC5, CRC16:  last = field_done;
      default:      last = 1'b0;
    endcase
  end

  assign bits.active      = (state != IDLE);
  assign bits.data_bit    = data_bit;
  assign bits.stuff_start = (state == PID) && (bit_cnt == '0);
  assign bits.last        = last;

  always_ff @(posedge clk or negedge rst_L) begin
    if (!rst_L) begin
      state   <= IDLE;
      bit_cnt <= '0;
    end else if (accept) begin
      state   <= SYNC;
      bit_cnt <= '0;
    end else if (step) begin
      if (field_done) begin
        bit_cnt <= '0;
        case (state)
          SYNC:    state <= PID;
          PID:     state <= pid_is_token ? ADDR : (pid_is_data ? DATA : IDLE);
          ADDR:    state <= ENDP;
          ENDP:    state <= CRC5;
          DATA:    state <= CRC16;
          default: state <= IDLE;
        endcase
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pkt_q <= pkt;
    end
  end

  // crc5 over addr and endp
  usb_crc_gen #(
    .WIDTH(`USB_CRC5_BITS),
    .POLY (`USB_CRC5_POLY)
  ) crc5 (
    .clk  (clk),
    .rst_L(rst_L),
    .clear(accept),
    .shift(step && ((state == ADDR) || (state == ENDP))),
    .din  (data_bit),
    .crc  (crc5_rem)
  );

  // crc16 over the payload
  usb_crc_gen #(
    .WIDTH(`USB_CRC16_BITS),
    .POLY (`USB_CRC16_POLY)
  ) crc16 (
    .clk  (clk),
    .rst_L(rst_L),
    .clear(accept),
    .shift(step && (state == DATA)),
    .din  (data_bit),
    .crc  (crc16_rem)
  );

endmodule : usb_pkt_serializer

// File: usb_crc_gen.sv
// serial crc generator
// linear feedback register fed one message bit per shift,
// preset to all ones on reset and on clear
`timescale 1ns/1ns

module usb_crc_gen #(
  parameter int               WIDTH = 5,
  parameter logic [WIDTH-1:0] POLY  = 5'h05
) (
  input  logic             clk,
  input  logic             rst_L,
  input  logic             clear,
  input  logic             shift,
  input  logic             din,
  output logic [WIDTH-1:0] crc
);

  logic             feedback;
  logic [WIDTH-1:0] crc_next;

  // msb out of the register xor the incoming bit decides the fold
  assign feedback = crc[WIDTH-1] ^ din;
  assign crc_next = {crc[WIDTH-2:0], 1'b0} ^ (feedback ? POLY : '0);

  always_ff @(posedge clk or negedge rst_L) begin
    if (!rst_L) begin
      crc <= '1;
    end else if (clear) begin
      // new packet starts from all ones
      crc <= '1;
    end else if (shift) begin
      crc <= crc_next;
    end
  end

endmodule : usb_crc_gen

// File: tx_bit_if.sv
// raw bit stream between the packet serializer and the bit stuffer
// the serializer holds everything while stall is high
`timescale 1ns/1ns

interface tx_bit_if;

  logic active;
  logic data_bit;
  logic stuff_start;
  logic last;
  logic stall;

  // serializer side
  modport ser (
    output active, data_bit, stuff_start, last,
    input  stall
  );

  // stuffer side
  modport stuff (
    input  active, data_bit, stuff_start, last,
    output stall
  );

endinterface : tx_bit_if

// File: usb_tx_pkg.sv
// usb transmit types
// pid codes and the packet layout handed to the serializer
`include "usb_tx_cfg.svh"

package usb_tx_pkg;

  // pid byte as sent on the wire, check nibble in the upper half
  typedef enum logic [`USB_PID_BITS-1:0] {
    OUT   = 8'b1110_0001,
    IN    = 8'b0110_1001,
    DATA0 = 8'b1100_0011,
    ACK   = 8'b1101_0010,
    NAK   = 8'b0101_1010
  } pid_e;

  // one outgoing packet
  // addr and endp only matter for tokens, data only for DATA0
  typedef struct packed {
    pid_e                      pid;
    logic [`USB_ADDR_BITS-1:0] addr;
    logic [`USB_ENDP_BITS-1:0] endp;
    logic [`USB_DATA_BITS-1:0] data;
  } tx_pkt_t;

endpackage : usb_tx_pkg

// File: usb_tx_cfg.svh
// usb transmit configuration
// field widths, stuffing run length, eop length and crc polynomials
`ifndef USB_TX_CFG_SVH
`define USB_TX_CFG_SVH

// packet field widths
`define USB_SYNC_BITS 8
`define USB_PID_BITS 8
`define USB_ADDR_BITS 7
`define USB_ENDP_BITS 4
`define USB_DATA_BITS 64

// crc5 is x^5 + x^2 + 1
`define USB_CRC5_BITS 5
`define USB_CRC5_POLY 5'h05

// crc16 is x^16 + x^15 + x^2 + 1
`define USB_CRC16_BITS 16
`define USB_CRC16_POLY 16'h8005

// ones in a row before a zero is stuffed
`define USB_STUFF_RUN 6

// se0 cycles at the end of a packet
`define USB_EOP_SE0_CYCLES 2

`endif
